// File: test/sprite_testdata.txt
# A attr_address data (hex, bank in address bits 4:3) | S sheet_address data (hex)
# P name displayed_line x expected_colour (line and x decimal, colour hex)
A 00 0C04
A 08 1C01
A 10 0002
A 18 0000
A 01 1408
A 09 1C01
A 11 0001
A 19 0040
A 02 1814
A 0A 0C00
A 12 0007
A 1A 0080
A 03 2418
A 0B 0C05
A 13 0005
A 1B 0080
A 04 AC20
A 0C 1C03
A 14 0004
A 1C 0100
A 05 0000
A 06 0000
A 07 3C24
A 0F 0C04
A 17 0004
A 1F 00C0
S 000 4321
S 001 8765
S 020 0CBA
S 021 FED0
S 040 0109
S 041 3020
S 080 7777
S 0C0 E0E0
S 100 2222
S 101 3333
S 120 9999
S 121 AAAA
S 140 5555
S 141 6666
P single_first_pixel 2 4 11
P single_fourth_pixel 2 7 14
P overlap_high_index 2 8 29
P transparent_over_lower 2 9 16
P transparent_over_empty 2 12 00
P disabled_sprite 2 20 00
P second_row_stride128 3 4 1A
P transparent_second_row 3 7 00
P cleared_after_display 3 13 00
P cleared_next_line 4 5 00
P stride256_first_row 4 33 52
P y_range_before 5 24 00
P stride256_second_row 5 34 55
P transparent_top_sprite 5 36 56
P overlap_top_sprite 5 37 7E
P y_range_inside 6 25 47
P cleared_stride256 6 34 00
P y_range_after 7 26 00

// File: vlog.f
common/video_pkg.sv
common/sprite_pkg.sv
source/bram.sv
source/video_timing.sv
source/sheet_memory.sv
sprite/sprite_controller.sv
source/sprite_subsystem.sv
test/sprite_checker.sv
test/tb_sprite.sv

// File: test/tb_sprite.sv
// Testbench top for the sprite engine, loads writes and probes from the data file and runs one check
`timescale 1ns/100ps

module tb_sprite;

	import video_pkg::*;
	import sprite_pkg::*;

	localparam int SPRITE_BITS  = 3;
	localparam int H_ACTIVE     = 64;
	localparam int H_TOTAL      = 160;
	localparam int V_TOTAL      = 8;
	localparam int MEM_LATENCY  = 3;
	localparam int RESET_CYCLES = 3;
	// Probes all fall in frame 1, three frames leave a full frame spare
	localparam int TIMEOUT_CYCLES = 3 * H_TOTAL * V_TOTAL + RESET_CYCLES;

	logic                          CLK;
	logic                          RSTb;
	logic [SPRITE_BITS+1:0]        attr_address;
	attr_word_t                    attr_data;
	logic                          attr_wr;
	logic [SHEET_ADDRESS_BITS-1:0] sheet_address;
	sheet_word_t                   sheet_data;
	logic                          sheet_wr;
	coord_t                        display_x;
	coord_t                        display_y;
	logic                          h_tick;
	logic                          v_tick;
	logic                          render_en;
	pixel_t                        color_index;

	logic probes_done;
	int   pass_count;
	int   fail_count;
	logic load_ok;

	// Host writes from the data file, applied in order after reset
	logic        wr_is_sheet [$];
	logic [15:0] wr_address [$];
	logic [15:0] wr_data [$];

	sprite_subsystem #(
		.SPRITE_BITS (SPRITE_BITS),
		.H_ACTIVE    (H_ACTIVE),
		.H_TOTAL     (H_TOTAL),
		.V_TOTAL     (V_TOTAL),
		.MEM_LATENCY (MEM_LATENCY)
	) dut (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.attr_address  (attr_address),
		.attr_data     (attr_data),
		.attr_wr       (attr_wr),
		.sheet_address (sheet_address),
		.sheet_data    (sheet_data),
		.sheet_wr      (sheet_wr),
		.display_x     (display_x),
		.display_y     (display_y),
		.h_tick        (h_tick),
		.v_tick        (v_tick),
		.render_en     (render_en),
		.color_index   (color_index)
	);

	sprite_checker #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_TOTAL  (V_TOTAL)
	) probe_check (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.display_x   (display_x),
		.display_y   (display_y),
		.h_tick      (h_tick),
		.v_tick      (v_tick),
		.render_en   (render_en),
		.color_index (color_index),
		.probes_done (probes_done),
		.pass_count  (pass_count),
		.fail_count  (fail_count)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic load_testdata(output logic ok);
		int          fd;
		int          fields;
		string       line;
		string       kind;
		string       name;
		logic [15:0] address;
		logic [15:0] data;
		int          line_number;
		int          x;
		logic [7:0]  expected;

		ok = 1'b1;
		fd = $fopen("test/sprite_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open test/sprite_testdata.txt for reading");
			ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				kind = "";
				fields = $fgets(line, fd);
				fields = $sscanf(line, "%s", kind);
				if ((fields == 1) && (kind != "#")) begin
					if ((kind == "A") || (kind == "S")) begin
						fields = $sscanf(line, "%s %h %h", kind, address, data);
						wr_is_sheet.push_back(kind == "S");
						wr_address.push_back(address);
						wr_data.push_back(data);
					end else if (kind == "P") begin
						fields = $sscanf(line, "%s %s %d %d %h", kind, name, line_number, x,
							expected);
						probe_check.add_probe(name, coord_t'(line_number), coord_t'(x), expected);
					end
					if (((kind == "P") && (fields != 5)) || ((kind != "P") && (fields != 3))) begin
						$display("Malformed record in data file: %s", line);
						ok = 1'b0;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// One write per cycle, strobe dropped after the last one
	task automatic apply_writes();
		for (int i = 0; i < wr_data.size(); i++) begin
			@(posedge CLK);
			if (wr_is_sheet[i]) begin
				sheet_address <= wr_address[i][SHEET_ADDRESS_BITS-1:0];
				sheet_data    <= wr_data[i];
				sheet_wr      <= 1'b1;
				attr_wr       <= 1'b0;
			end else begin
				attr_address <= wr_address[i][SPRITE_BITS+1:0];
				attr_data    <= wr_data[i];
				attr_wr      <= 1'b1;
				sheet_wr     <= 1'b0;
			end
		end
		@(posedge CLK);
		attr_wr  <= 1'b0;
		sheet_wr <= 1'b0;
	endtask

	initial begin
		RSTb          = 1'b0;
		attr_address  = '0;
		attr_data     = '0;
		attr_wr       = 1'b0;
		sheet_address = '0;
		sheet_data    = '0;
		sheet_wr      = 1'b0;

		load_testdata(load_ok);
		if (!load_ok) begin
			$display("Data file could not be read, no probes were run");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge CLK);
			RSTb <= 1'b1;
			apply_writes();
			wait (probes_done);
			@(posedge CLK);
			$display("Tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
				fail_count);
			if ((fail_count == 0) && (pass_count > 0)) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, probes never completed", TIMEOUT_CYCLES);
		$display("Passed %0d, failed %0d before the timeout", pass_count, fail_count);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: test/sprite_checker.sv
// Testbench monitor for the sprite engine, checking raster timing in frame 0 and probes in frame 1
`timescale 1ns/100ps

module sprite_checker #(
	parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEFAULT,
	parameter int H_TOTAL  = video_pkg::H_TOTAL_DEFAULT,
	parameter int V_TOTAL  = video_pkg::V_TOTAL_DEFAULT
) (
	input  logic               CLK,
	input  logic               RSTb,
	input  video_pkg::coord_t  display_x,
	input  video_pkg::coord_t  display_y,
	input  logic               h_tick,
	input  logic               v_tick,
	input  logic               render_en,
	input  sprite_pkg::pixel_t color_index,
	output logic               probes_done,
	output int                 pass_count,
	output int                 fail_count
);

	import video_pkg::*;
	import sprite_pkg::*;

	localparam int MAX_PROBES  = 64;
	localparam int CHECK_FRAME = 1;

	string  probe_name [MAX_PROBES];
	coord_t probe_line [MAX_PROBES];
	coord_t probe_x [MAX_PROBES];
	pixel_t probe_expected [MAX_PROBES];
	logic   probe_checked [MAX_PROBES];

	int probe_count   = 0;
	int checked_count = 0;
	int passed        = 0;
	int failed        = 0;

	// Raster position of the previous cycle, which color_index now answers
	int     frames_seen = 0;
	int     seen_frame  = 0;
	coord_t seen_x;
	coord_t seen_y;
	logic   seen_valid  = 1'b0;

	// Reference raster position, stepped by the frame geometry from reset
	int   ref_x         = 0;
	int   ref_y         = 0;
	int   ref_frame     = 0;
	int   raster_errors = 0;
	logic raster_done   = 1'b0;

	assign pass_count  = passed;
	assign fail_count  = failed;
	assign probes_done = (probe_count > 0) && (checked_count == probe_count) && raster_done;

	// Called by the testbench top while it reads the data file
	task automatic add_probe(input string name, input coord_t line, input coord_t x,
			input pixel_t expected);
		if (probe_count < MAX_PROBES) begin
			probe_name[probe_count]     = name;
			probe_line[probe_count]     = line;
			probe_x[probe_count]        = x;
			probe_expected[probe_count] = expected;
			probe_checked[probe_count]  = 1'b0;
			probe_count = probe_count + 1;
		end else begin
			$display("Probe table is full, probe %s was not registered", name);
			failed = failed + 1;
		end
	endtask

	always @(posedge CLK) begin
		int   frame_now;
		logic exp_h_tick;
		logic exp_v_tick;
		logic exp_render_en;

		// First cycle of a frame is flagged by v_tick before the count moves
		frame_now = v_tick ? frames_seen : frames_seen - 1;

		// Line tick at x = 0, frame tick at x = y = 0, active below H_ACTIVE
		exp_h_tick    = (ref_x == 0);
		exp_v_tick    = exp_h_tick && (ref_y == 0);
		exp_render_en = (ref_x < H_ACTIVE);

		if (!RSTb) begin
			ref_x     = 0;
			ref_y     = 0;
			ref_frame = 0;
		end else if (!raster_done) begin
			if ((display_x !== coord_t'(ref_x)) || (display_y !== coord_t'(ref_y))
					|| (h_tick !== exp_h_tick) || (v_tick !== exp_v_tick)
					|| (render_en !== exp_render_en)) begin
				if (raster_errors == 0) begin
					$display(
						"ERROR raster_timing: expected x%0d y%0d hve %b%b%b actual x%0d y%0d hve %b%b%b",
						ref_x, ref_y, exp_h_tick, exp_v_tick, exp_render_en,
						display_x, display_y, h_tick, v_tick, render_en);
				end
				raster_errors = raster_errors + 1;
			end
			if (ref_x == H_TOTAL - 1) begin
				ref_x = 0;
				if (ref_y == V_TOTAL - 1) begin
					ref_y     = 0;
					ref_frame = ref_frame + 1;
				end else begin
					ref_y = ref_y + 1;
				end
			end else begin
				ref_x = ref_x + 1;
			end
			// A whole frame compared
			if (ref_frame == 1) begin
				if (raster_errors == 0) begin
					$display("PASS raster_timing: %0d cycles matched", H_TOTAL * V_TOTAL);
					passed = passed + 1;
				end else begin
					$display("FAIL raster_timing: %0d cycles mismatched", raster_errors);
					failed = failed + 1;
				end
				raster_done = 1'b1;
			end
		end

		if (seen_valid && (seen_frame == CHECK_FRAME)) begin
			for (int i = 0; i < probe_count; i++) begin
				if (!probe_checked[i] && (probe_line[i] == seen_y)
						&& (probe_x[i] == seen_x)) begin
					if (color_index === probe_expected[i]) begin
						$display("PASS %s: line %0d x %0d colour %02h", probe_name[i],
							seen_y, seen_x, color_index);
						passed = passed + 1;
					end else begin
						$display("ERROR %s: expected %02h actual %02h", probe_name[i],
							probe_expected[i], color_index);
						failed = failed + 1;
					end
					probe_checked[i] = 1'b1;
					checked_count = checked_count + 1;
				end
			end
		end

		if (RSTb) begin
			if (v_tick) begin
				frames_seen <= frames_seen + 1;
			end
			seen_valid <= 1'b1;
			seen_frame <= frame_now;
			seen_x     <= display_x;
			seen_y     <= display_y;
		end else begin
			seen_valid <= 1'b0;
		end
	end

endmodule

// File: source/sprite_subsystem.sv
// Sprite engine top level joining raster timing, sprite controller and sheet memory
`timescale 1ns/100ps

module sprite_subsystem #(
	parameter int SPRITE_BITS = 3,
	parameter int H_ACTIVE    = video_pkg::H_ACTIVE_DEFAULT,
	parameter int H_TOTAL     = video_pkg::H_TOTAL_DEFAULT,
	parameter int V_TOTAL     = video_pkg::V_TOTAL_DEFAULT,
	parameter int MEM_LATENCY = 3
) (
	input  logic                                      CLK,
	input  logic                                      RSTb,
	input  logic [SPRITE_BITS+1:0]                    attr_address,
	input  sprite_pkg::attr_word_t                    attr_data,
	input  logic                                      attr_wr,
	input  logic [sprite_pkg::SHEET_ADDRESS_BITS-1:0] sheet_address,
	input  sprite_pkg::sheet_word_t                   sheet_data,
	input  logic                                      sheet_wr,
	output video_pkg::coord_t                         display_x,
	output video_pkg::coord_t                         display_y,
	output logic                                      h_tick,
	output logic                                      v_tick,
	output logic                                      render_en,
	output sprite_pkg::pixel_t                        color_index
);

	import sprite_pkg::*;

	// Fetch channel between controller and sheet store
	logic [15:0] fetch_address;
	logic        fetch_valid;
	sheet_word_t fetch_data;
	logic        fetch_ready;

	video_timing #(
		.H_ACTIVE (H_ACTIVE),
		.H_TOTAL  (H_TOTAL),
		.V_TOTAL  (V_TOTAL)
	) u_timing (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.display_x (display_x),
		.display_y (display_y),
		.h_tick    (h_tick),
		.v_tick    (v_tick),
		.render_en (render_en)
	);

	sprite_controller #(
		.SPRITE_BITS (SPRITE_BITS),
		.H_ACTIVE    (H_ACTIVE)
	) u_controller (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.attr_address  (attr_address),
		.attr_data     (attr_data),
		.attr_wr       (attr_wr),
		.h_tick        (h_tick),
		.display_x     (display_x),
		.display_y     (display_y),
		.color_index   (color_index),
		.fetch_address (fetch_address),
		.fetch_valid   (fetch_valid),
		.fetch_data    (fetch_data),
		.fetch_ready   (fetch_ready)
	);

	sheet_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_sheet (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.sheet_address (sheet_address),
		.sheet_data    (sheet_data),
		.sheet_wr      (sheet_wr),
		.fetch_address (fetch_address),
		.fetch_valid   (fetch_valid),
		.fetch_data    (fetch_data),
		.fetch_ready   (fetch_ready)
	);

endmodule

// File: sprite/sprite_controller.sv
// Sprite engine core: attribute banks, per-line sprite walk, sheet fetch and scanline double buffer
`timescale 1ns/100ps

module sprite_controller #(
	parameter int SPRITE_BITS = 3,
	parameter int H_ACTIVE    = video_pkg::H_ACTIVE_DEFAULT
) (
	input  logic                     CLK,
	input  logic                     RSTb,

	input  logic [SPRITE_BITS+1:0]   attr_address,
	input  sprite_pkg::attr_word_t   attr_data,
	input  logic                     attr_wr,

	input  logic                     h_tick,
	input  video_pkg::coord_t        display_x,
	input  video_pkg::coord_t        display_y,
	output sprite_pkg::pixel_t       color_index,

	output logic [15:0]              fetch_address,
	output logic                     fetch_valid,
	input  sprite_pkg::sheet_word_t  fetch_data,
	input  logic                     fetch_ready
);

	import video_pkg::*;
	import sprite_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_BEGIN,
		S_LOAD,
		S_ADDRESS,
		S_WAIT,
		S_DRAW,
		S_FINISH
	} state_e;

	state_e state;

	logic [SPRITE_BITS-1:0] sprite;
	logic [SPRITE_BITS-1:0] attr_sprite;
	bank_e                  attr_bank;
	attr_word_t             attr_rd_data [4];

	attr_word_t x_word;
	attr_word_t y_word;
	attr_word_t h_word;
	attr_word_t a_word;

	// Per-sprite working registers
	coord_t      cur_x;
	coord_t      row;
	logic [3:0]  palette;
	sheet_word_t fetch_word;
	logic [17:0] nib_addr;
	logic [Y_WIDTH_MSB-Y_WIDTH_LSB:0] count;

	logic       hit;
	logic       last_sprite;
	logic [3:0] draw_nibble;
	logic       draw_wr;
	pixel_t     draw_pixel;

	// Scanline buffers, back one is drawn while the other is shown
	logic   back_buffer;
	logic   clear_en;
	coord_t clear_address;
	coord_t scan_wr_address [2];
	pixel_t scan_wr_data [2];
	logic   scan_wr [2];
	pixel_t scan_rd_data [2];

	assign attr_sprite = attr_address[SPRITE_BITS-1:0];
	assign attr_bank   = bank_e'(attr_address[SPRITE_BITS +: 2]);

	for (genvar b = 0; b < 4; b++) begin : g_attr_bank
		bram #(
			.word_t       (attr_word_t),
			.ADDRESS_BITS (SPRITE_BITS)
		) u_bank (
			.CLK        (CLK),
			.rd_address (sprite),
			.rd_data    (attr_rd_data[b]),
			.wr_address (attr_sprite),
			.wr_data    (attr_data),
			.wr         (attr_wr && (attr_bank == bank_e'(b)))
		);
	end

	assign x_word = attr_rd_data[BANK_X];
	assign y_word = attr_rd_data[BANK_Y];
	assign h_word = attr_rd_data[BANK_H];
	assign a_word = attr_rd_data[BANK_A];

	assign hit = x_word[X_ENABLE_BIT]
		&& (display_y >= coord_t'(y_word[Y_START_MSB:Y_START_LSB]))
		&& (display_y <= coord_t'(h_word[H_END_MSB:H_END_LSB]));
	assign last_sprite = (sprite == '1);

	// Nibble position within the word follows the pixel count
	assign draw_nibble = fetch_word[{count[1:0], 2'b00} +: 4];
	assign draw_wr     = (state == S_DRAW) && (draw_nibble != 4'd0);
	assign draw_pixel  = {palette, draw_nibble};

	assign fetch_valid   = (state == S_WAIT);
	assign fetch_address = nib_addr[17:2];

	// Clear one pixel behind the beam, wrapping to the line end at x = 0
	assign clear_address = (display_x == '0) ? coord_t'(H_ACTIVE - 1) : display_x - 1'b1;

	for (genvar b = 0; b < 2; b++) begin : g_scanline
		assign scan_wr_address[b] = (back_buffer == 1'(b)) ? cur_x : clear_address;
		assign scan_wr_data[b]    = (back_buffer == 1'(b)) ? draw_pixel : '0;
		assign scan_wr[b]         = (back_buffer == 1'(b)) ? draw_wr : clear_en;

		bram #(
			.word_t       (pixel_t),
			.ADDRESS_BITS (COORD_BITS)
		) u_line (
			.CLK        (CLK),
			.rd_address (display_x),
			.rd_data    (scan_rd_data[b]),
			.wr_address (scan_wr_address[b]),
			.wr_data    (scan_wr_data[b]),
			.wr         (scan_wr[b])
		);
	end

	// Both halves read display_x, so the swap at x = 0 picks the right word
	assign color_index = scan_rd_data[~back_buffer];

	// Render FSM
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state       <= S_IDLE;
			sprite      <= '0;
			count       <= '0;
			back_buffer <= 1'b0;
			clear_en    <= 1'b0;
		end else if (h_tick) begin
			back_buffer <= ~back_buffer;
			clear_en    <= 1'b1;
			sprite      <= '0;
			state       <= S_BEGIN;
		end else begin
			case (state)
				// Attribute read takes a cycle
				S_BEGIN: state <= S_LOAD;
				S_LOAD: begin
					count <= '0;
					if (hit) begin
						state <= S_ADDRESS;
					end else begin
						sprite <= sprite + 1'b1;
						state  <= last_sprite ? S_IDLE : S_BEGIN;
					end
				end
				S_ADDRESS: state <= S_WAIT;
				S_WAIT: begin
					if (fetch_ready) begin
						state <= S_DRAW;
					end
				end
				S_DRAW: begin
					count <= count + 1'b1;
					if (count == y_word[Y_WIDTH_MSB:Y_WIDTH_LSB]) begin
						state <= S_FINISH;
					end else if (count[1:0] == 2'b11) begin
						state <= S_ADDRESS;
					end
				end
				S_FINISH: begin
					sprite <= sprite + 1'b1;
					state  <= last_sprite ? S_IDLE : S_BEGIN;
				end
				default: ;
			endcase
		end
	end

	// Working registers for the sprite being drawn
	always_ff @(posedge CLK) begin
		case (state)
			S_LOAD: begin
				cur_x   <= x_word[X_MSB:X_LSB];
				palette <= x_word[X_PAL_MSB:X_PAL_LSB];
				row     <= display_y - coord_t'(y_word[Y_START_MSB:Y_START_LSB]);
			end
			S_ADDRESS: begin
				// Nibble address of base + row * stride + u
				if (x_word[X_STRIDE_BIT]) begin
					nib_addr <= {a_word, 2'b00} + {row, 8'd0} + 18'(count);
				end else begin
					nib_addr <= {a_word, 2'b00} + {1'b0, row, 7'd0} + 18'(count);
				end
			end
			S_WAIT: begin
				if (fetch_ready) begin
					fetch_word <= fetch_data;
				end
			end
			S_DRAW: cur_x <= cur_x + 1'b1;
			default: ;
		endcase
	end

endmodule

// File: source/sheet_memory.sv
// Sprite sheet store: host writes directly, fetch reads answered after a fixed latency
`timescale 1ns/100ps

module sheet_memory #(
	parameter int MEM_LATENCY = 3
) (
	input  logic                                   CLK,
	input  logic                                   RSTb,
	input  logic [sprite_pkg::SHEET_ADDRESS_BITS-1:0] sheet_address,
	input  sprite_pkg::sheet_word_t                sheet_data,
	input  logic                                   sheet_wr,
	input  logic [15:0]                            fetch_address,
	input  logic                                   fetch_valid,
	output sprite_pkg::sheet_word_t                fetch_data,
	output logic                                   fetch_ready
);

	import sprite_pkg::*;

	localparam int COUNT_BITS = $clog2(MEM_LATENCY + 1);

	logic [COUNT_BITS-1:0] count;
	logic                  waiting;

	bram #(
		.word_t       (sheet_word_t),
		.ADDRESS_BITS (SHEET_ADDRESS_BITS)
	) u_store (
		.CLK        (CLK),
		.rd_address (fetch_address[SHEET_ADDRESS_BITS-1:0]),
		.rd_data    (fetch_data),
		.wr_address (sheet_address),
		.wr_data    (sheet_data),
		.wr         (sheet_wr)
	);

	// Ready comes MEM_LATENCY cycles after valid is first seen
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count       <= '0;
			waiting     <= 1'b0;
			fetch_ready <= 1'b0;
		end else begin
			fetch_ready <= 1'b0;
			if (waiting) begin
				if (count == COUNT_BITS'(MEM_LATENCY - 1)) begin
					waiting     <= 1'b0;
					count       <= '0;
					fetch_ready <= 1'b1;
				end else begin
					count <= count + 1'b1;
				end
			end else if (fetch_valid && !fetch_ready) begin
				// A latency of one answers straight away
				if (MEM_LATENCY == 1) begin
					fetch_ready <= 1'b1;
				end else begin
					waiting <= 1'b1;
					count   <= COUNT_BITS'(1);
				end
			end
		end
	end

endmodule

// File: source/video_timing.sv
// Raster timing generator: wrapping counters giving coordinates, line and frame ticks, active flag
`timescale 1ns/100ps

module video_timing #(
	parameter int H_ACTIVE = video_pkg::H_ACTIVE_DEFAULT,
	parameter int H_TOTAL  = video_pkg::H_TOTAL_DEFAULT,
	parameter int V_TOTAL  = video_pkg::V_TOTAL_DEFAULT
) (
	input  logic              CLK,
	input  logic              RSTb,
	output video_pkg::coord_t display_x,
	output video_pkg::coord_t display_y,
	output logic              h_tick,
	output logic              v_tick,
	output logic              render_en
);

	import video_pkg::*;

	// Totals beyond the coordinate range wrap at the range end
	localparam int COORD_SPAN = 2 ** COORD_BITS;
	localparam int H_LAST = (H_TOTAL > COORD_SPAN) ? COORD_SPAN - 1 : H_TOTAL - 1;
	localparam int V_LAST = (V_TOTAL > COORD_SPAN) ? COORD_SPAN - 1 : V_TOTAL - 1;

	coord_t h_count;
	coord_t v_count;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == coord_t'(H_LAST)) begin
			h_count <= '0;
			v_count <= (v_count == coord_t'(V_LAST)) ? '0 : v_count + 1'b1;
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign display_x = h_count;
	assign display_y = v_count;
	assign h_tick    = (h_count == '0);
	assign v_tick    = h_tick && (v_count == '0);
	assign render_en = (h_count < H_ACTIVE);

endmodule

// File: source/bram.sv
// Block RAM with one write port and a registered read port, payload chosen by type parameter
`timescale 1ns/100ps

module bram #(
	parameter type word_t       = logic [15:0],
	parameter int  ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_address,
	output word_t                   rd_data,
	input  logic [ADDRESS_BITS-1:0] wr_address,
	input  word_t                   wr_data,
	input  logic                    wr
);

	word_t mem [2**ADDRESS_BITS];

	// Read returns the old word when both ports hit one address
	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[wr_address] <= wr_data;
		end
		rd_data <= mem[rd_address];
	end

endmodule

// File: common/sprite_pkg.sv
// Sprite attribute layout, bank codes, pixel and sheet word types, imported by the sprite engine RTL
package sprite_pkg;

	typedef logic [15:0] attr_word_t;
	typedef logic [15:0] sheet_word_t;

	// Palette high nibble over the sheet nibble
	typedef logic [7:0] pixel_t;

	// Attribute bank, from the top two bits of the host address
	typedef enum logic [1:0] {
		BANK_X = 2'd0,
		BANK_Y = 2'd1,
		BANK_H = 2'd2,
		BANK_A = 2'd3
	} bank_e;

	// X word
	localparam int X_LSB        = 0;
	localparam int X_MSB        = 9;
	localparam int X_ENABLE_BIT = 10;
	localparam int X_PAL_LSB    = 11;
	localparam int X_PAL_MSB    = 14;
	// 0 gives 128 pixels per sheet row, 1 gives 256
	localparam int X_STRIDE_BIT = 15;

	// Y word holds the first line and width minus one
	localparam int Y_START_LSB = 0;
	localparam int Y_START_MSB = 9;
	localparam int Y_WIDTH_LSB = 10;
	localparam int Y_WIDTH_MSB = 15;

	// H word, last line covered
	localparam int H_END_LSB = 0;
	localparam int H_END_MSB = 9;

	// Sheet store depth in words
	localparam int SHEET_ADDRESS_BITS = 12;

endpackage

// File: common/video_pkg.sv
// Raster coordinate type and default frame timing, imported by the timing, controller and top RTL
package video_pkg;

	// Raster counters and coordinates share one width
	localparam int COORD_BITS = 10;

	typedef logic [COORD_BITS-1:0] coord_t;

	// Full-size frame, used when the top level is not overridden
	localparam int H_ACTIVE_DEFAULT = 800;
	localparam int H_TOTAL_DEFAULT  = 1056;
	localparam int V_TOTAL_DEFAULT  = 628;

endpackage
